// ==== logic/eth_settings.svh ====
`ifndef ETH_SETTINGS_SVH
`define ETH_SETTINGS_SVH

// Entries in each stream FIFO
`define ETH_FIFO_DEPTH 16

// Width of one stream byte
`define ETH_DATA_WIDTH 8

// 0x55 bytes sent ahead of the delimiter
`define ETH_PREAMBLE_BYTES 7

// Minimum idle time between frames, in byte times
`define ETH_IFG_BYTES 12

`define ETH_SFD 8'hD5  // Start-frame delimiter

`endif

// ==== logic/eth_stream_pkg.sv ====
`include "eth_settings.svh"

package eth_stream_pkg;

    typedef logic [`ETH_DATA_WIDTH-1:0] eth_byte_t;

    // One stream beat, byte plus end-of-frame flag
    typedef struct packed {
        eth_byte_t data;
        logic      last;  // Final byte of the frame
    } stream_beat_t;

endpackage

// ==== logic/rgmii_line_pkg.sv ====
package rgmii_line_pkg;

    typedef logic [3:0] nibble_t;  // One line transfer

    // Preamble pattern, half of 0x55
    localparam nibble_t PRE_NIBBLE = 4'h5;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_PREAMBLE,  // Preamble and delimiter
        TX_DATA,
        TX_GAP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_HUNT,  // Searching for the delimiter
        RX_DATA,
        RX_DROP
    } rx_state_t;

endpackage

// ==== logic/axis_if.sv ====
interface axis_if
    import eth_stream_pkg::*;
();

    stream_beat_t data;
    logic         valid;
    logic         ready;

    // Producer side
    modport src (
        output data,
        output valid,
        input  ready
    );

    modport snk (
        input  data,
        input  valid,
        output ready
    );

    modport mon (input data, input valid, input ready);  // Passive observer

endinterface

// ==== logic/beat_fifo.sv ====
`include "eth_settings.svh"

module beat_fifo
    import eth_stream_pkg::*;
#(
    parameter type payload_t = stream_beat_t,
    parameter int  DEPTH     = `ETH_FIFO_DEPTH
) (
    input logic clk_125,
    input logic rst_n,
    axis_if.snk wr,
    axis_if.src rd
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t      mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic          push;
    logic          pop;
    logic          space;  // Registered, so low out of reset

    // Pointer step with wrap for any depth
    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push     = wr.valid && wr.ready;
    assign pop      = rd.valid && rd.ready;
    assign wr.ready = space;
    assign rd.valid = (count != '0);
    assign rd.data  = mem[rd_ptr];  // Head of queue

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (!push && pop) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            space  <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= bump(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= bump(rd_ptr);
            end
            count <= count_next;
            space <= (count_next != CW'(DEPTH));
        end
    end

    always_ff @(posedge clk_125) begin
        if (push) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    // Registered ready must already be low once the last slot is taken
    a_no_push_full: assert property (@(posedge clk_125) disable iff (!rst_n)
        (count == CW'(DEPTH)) |-> !push);

    a_head_stable: assert property (@(posedge clk_125) disable iff (!rst_n)
        (rd.valid && !rd.ready) |=> (rd.valid && $stable(rd.data)));

endmodule

// ==== logic/rgmii_tx_framer.sv ====
`include "eth_settings.svh"

module rgmii_tx_framer
    import eth_stream_pkg::*;
    import rgmii_line_pkg::*;
(
    input  logic    clk_125,
    input  logic    rst_n,
    axis_if.mon     watch,
    axis_if.snk     bytes,
    output nibble_t txd,
    output logic    txctl
);

    localparam eth_byte_t SFD      = `ETH_SFD;
    localparam int        PRE_NIBS = 2 * `ETH_PREAMBLE_BYTES + 2;  // Delimiter included
    localparam int        GAP_CYC  = 2 * `ETH_IFG_BYTES;
    localparam int        CNT_W    = $clog2(PRE_NIBS + GAP_CYC);
    localparam int        PW       = $clog2(`ETH_FIFO_DEPTH + 1);

    tx_state_t      state;
    logic [CNT_W-1:0] cnt;
    logic           hi_phase;    // Sending the upper nibble
    logic [PW-1:0]  pending;     // Frames fully held in the FIFO
    logic           frame_done;
    logic           start;

    assign frame_done  = watch.valid && watch.ready && watch.data.last;
    assign start       = (state == TX_IDLE) && (pending != '0);
    assign bytes.ready = (state == TX_DATA) && hi_phase;  // Pop during upper nibble

    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            pending <= '0;
        end else if (frame_done && !start) begin
            pending <= pending + 1'b1;
        end else if (!frame_done && start) begin
            pending <= pending - 1'b1;
        end
    end

    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            cnt      <= '0;
            hi_phase <= 1'b0;
            txctl    <= 1'b0;
            txd      <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    txctl <= 1'b0;
                    txd   <= '0;
                    if (start) begin
                        state <= TX_PREAMBLE;
                        cnt   <= '0;
                    end
                end
                TX_PREAMBLE: begin
                    txctl <= 1'b1;
                    cnt   <= cnt + 1'b1;
                    if (cnt == CNT_W'(PRE_NIBS - 2)) begin
                        txd <= SFD[3:0];
                    end else if (cnt == CNT_W'(PRE_NIBS - 1)) begin
                        txd      <= SFD[7:4];
                        state    <= TX_DATA;
                        hi_phase <= 1'b0;
                    end else begin
                        txd <= PRE_NIBBLE;
                    end
                end
                TX_DATA: begin
                    txctl    <= 1'b1;
                    hi_phase <= !hi_phase;
                    if (!hi_phase) begin
                        txd <= bytes.data.data[3:0];  // Low nibble first
                    end else begin
                        txd <= bytes.data.data[7:4];
                        if (bytes.data.last) begin
                            state <= TX_GAP;
                            cnt   <= '0;
                        end
                    end
                end
                TX_GAP: begin
                    txctl <= 1'b0;
                    txd   <= '0;
                    cnt   <= cnt + 1'b1;
                    if (cnt == CNT_W'(GAP_CYC - 1)) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // A frame is only started once its last byte is queued
    a_no_underrun: assert property (@(posedge clk_125) disable iff (!rst_n)
        (state == TX_DATA) |-> bytes.valid);

endmodule

// ==== logic/rgmii_rx_deframer.sv ====
`include "eth_settings.svh"

module rgmii_rx_deframer
    import eth_stream_pkg::*;
    import rgmii_line_pkg::*;
(
    input  logic    clk_125,
    input  logic    rst_n,
    input  nibble_t rxd,
    input  logic    rxctl,
    axis_if.src     bytes,
    output logic    overflow
);

    localparam eth_byte_t SFD = `ETH_SFD;

    rx_state_t    state;
    nibble_t      prev_nib;
    nibble_t      lo_nib;
    logic         hi_phase;
    eth_byte_t    hold_byte;   // Waits one byte time so last can be attached
    logic         hold_full;
    stream_beat_t out_beat;
    logic         out_valid;
    logic         emit;
    logic         emit_last;
    logic         blocked;     // Previous beat still not taken

    assign bytes.valid = out_valid;
    assign bytes.data  = out_beat;
    assign blocked     = out_valid && !bytes.ready;

    // Next low nibble or end of frame releases the held byte
    always_comb begin
        emit      = 1'b0;
        emit_last = 1'b0;
        if (state == RX_DATA && hold_full) begin
            emit      = !rxctl || !hi_phase;
            emit_last = !rxctl;
        end
    end

    always_ff @(posedge clk_125) begin
        prev_nib <= rxd;
    end

    always_ff @(posedge clk_125) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            hi_phase  <= 1'b0;
            hold_full <= 1'b0;
            out_valid <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            overflow <= 1'b0;
            if (out_valid && bytes.ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                RX_IDLE: if (rxctl) state <= RX_HUNT;
                RX_HUNT: begin
                    if (!rxctl) begin
                        state <= RX_IDLE;
                    end else if (prev_nib == SFD[3:0] && rxd == SFD[7:4]) begin
                        state     <= RX_DATA;
                        hi_phase  <= 1'b0;
                        hold_full <= 1'b0;
                    end
                end
                RX_DATA: begin
                    if (emit && blocked) begin
                        // Waiting beat becomes the frame end
                        state         <= RX_DROP;
                        overflow      <= 1'b1;
                        out_beat.last <= 1'b1;
                        hold_full     <= 1'b0;
                    end else begin
                        if (emit) begin
                            out_valid <= 1'b1;
                            out_beat  <= '{data: hold_byte, last: emit_last};
                            hold_full <= 1'b0;
                        end
                        if (!rxctl) begin
                            state <= RX_IDLE;  // A partial byte is discarded
                        end else begin
                            hi_phase <= !hi_phase;
                            if (hi_phase) begin
                                hold_byte <= {rxd, lo_nib};
                                hold_full <= 1'b1;
                            end else begin
                                lo_nib <= rxd;
                            end
                        end
                    end
                end
                RX_DROP: if (!rxctl && !out_valid) state <= RX_IDLE;
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_ovf_not_idle: assert property (@(posedge clk_125) disable iff (!rst_n)
        overflow |-> (state != RX_IDLE));

endmodule

// ==== logic/ethernet_mac_fifo.sv ====
`include "eth_settings.svh"

module ethernet_mac_fifo
    import eth_stream_pkg::*;
(
    input  logic       clk_125,
    input  logic       rst_n,
    input  logic [3:0] rgmii_phy_rxd,
    input  logic       rgmii_phy_rxctl,
    output logic [3:0] rgmii_phy_txd,
    output logic       rgmii_phy_txctl,
    input  logic [7:0] s_tx_axis_tdata,
    input  logic       s_tx_axis_tvalid,
    input  logic       s_tx_axis_tlast,
    output logic       s_tx_axis_trdy,
    output logic [7:0] m_rx_axis_tdata,
    output logic       m_rx_axis_tvalid,
    output logic       m_rx_axis_tlast,
    input  logic       m_rx_axis_trdy,
    output logic       rx_overflow
);

    axis_if tx_in ();
    axis_if tx_out ();
    axis_if rx_in ();
    axis_if rx_out ();

    // Slave port into the tx stream
    assign tx_in.data     = '{data: s_tx_axis_tdata, last: s_tx_axis_tlast};
    assign tx_in.valid    = s_tx_axis_tvalid;
    assign s_tx_axis_trdy = tx_in.ready;

    assign m_rx_axis_tdata  = rx_out.data.data;
    assign m_rx_axis_tlast  = rx_out.data.last;
    assign m_rx_axis_tvalid = rx_out.valid;
    assign rx_out.ready     = m_rx_axis_trdy;

    beat_fifo #(
        .payload_t (stream_beat_t),
        .DEPTH     (`ETH_FIFO_DEPTH)
    ) i_tx_fifo (
        .clk_125 (clk_125),
        .rst_n   (rst_n),
        .wr      (tx_in),
        .rd      (tx_out)
    );

    rgmii_tx_framer i_tx_framer (
        .clk_125 (clk_125),
        .rst_n   (rst_n),
        .watch   (tx_in),  // Counts frames as their last byte enters
        .bytes   (tx_out),
        .txd     (rgmii_phy_txd),
        .txctl   (rgmii_phy_txctl)
    );

    rgmii_rx_deframer i_rx_deframer (
        .clk_125  (clk_125),
        .rst_n    (rst_n),
        .rxd      (rgmii_phy_rxd),
        .rxctl    (rgmii_phy_rxctl),
        .bytes    (rx_in),
        .overflow (rx_overflow)
    );

    beat_fifo #(
        .payload_t (stream_beat_t),
        .DEPTH     (`ETH_FIFO_DEPTH)
    ) i_rx_fifo (
        .clk_125 (clk_125),
        .rst_n   (rst_n),
        .wr      (rx_in),
        .rd      (rx_out)
    );

endmodule

// ==== tb/eth_clk_gen.sv ====
module eth_clk_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_125,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_125 = 1'b0;
        forever #(PERIOD_NS / 2) clk_125 = ~clk_125;
    end

    // Release lands on a falling edge, like every other input
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_125);
        @(negedge clk_125);
        rst_n = 1'b1;
    end

endmodule

// ==== tb/eth_frame_checker.sv ====
`include "eth_settings.svh"

module eth_frame_checker
    import eth_stream_pkg::*;
    import rgmii_line_pkg::*;
(
    input logic      clk_125,
    input logic      rst_n,
    input nibble_t   txd,
    input logic      txctl,
    input eth_byte_t rx_tdata,
    input logic      rx_tvalid,
    input logic      rx_tlast,
    input logic      rx_trdy,
    input logic      rx_overflow
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MIN_GAP = 2 * `ETH_IFG_BYTES;

    stream_beat_t exp_beats[$];
    nibble_t      exp_nibs[$];
    int           exp_lens[$];  // txctl high time per frame
    int           check_errors = 0;
    int           end_errors   = 0;
    int           ovf_seen     = 0;
    int           err_base     = 0;
    int           ovf_base     = 0;
    int           tests_run    = 0;
    int           tests_failed = 0;
    int           high_cnt;
    int           low_cnt;
    logic         ctl_q;
    logic         framed;  // At least one frame seen on the line

    function automatic void expect_beat(input eth_byte_t data, input logic last);
        exp_beats.push_back('{data: data, last: last});
    endfunction

    function automatic void expect_nibble(input nibble_t nib);
        exp_nibs.push_back(nib);
    endfunction

    function automatic void expect_line_len(input int len);
        exp_lens.push_back(len);
    endfunction

    function automatic int outstanding();
        return exp_beats.size() + exp_nibs.size() + exp_lens.size();
    endfunction

    function automatic int total_errors();
        return check_errors + end_errors;
    endfunction

    function automatic void start_test();
        err_base = check_errors;
        ovf_base = ovf_seen;
    endfunction

    function automatic void finish_test(input string name, input int exp_ovf);
        int misses;
        int fails;
        misses = 0;
        if (outstanding() != 0) begin
            $display("Test %s: %0d bytes and %0d line nibbles never showed up",
                     name, exp_beats.size(), exp_nibs.size());
            misses++;
        end
        if (ovf_seen - ovf_base != exp_ovf) begin
            $display("Test %s: rx_overflow pulsed %0d times where %0d were wanted",
                     name, ovf_seen - ovf_base, exp_ovf);
            misses++;
        end
        end_errors += misses;
        fails = check_errors - err_base + misses;
        tests_run++;
        if (fails != 0) begin
            tests_failed++;
        end
        $display("Test %s: %s (%0d errors)", name, (fails == 0) ? "ok" : "failing", fails);
    endfunction

    function automatic void print_summary();
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors());
    endfunction

    always @(posedge clk_125) begin : watch_ports
        stream_beat_t beat;
        nibble_t      nib;
        int           len;
        if (!rst_n) begin
            ctl_q    = 1'b0;
            high_cnt = 0;
            low_cnt  = 0;
            framed   = 1'b0;
        end else begin
            if (rx_overflow) begin
                ovf_seen++;
            end
            if (rx_tvalid && rx_trdy) begin
                if (exp_beats.size() == 0) begin
                    check_errors++;
                    $display("Byte %02h received at %0t with no frame pending", rx_tdata, $time);
                end else begin
                    beat = exp_beats.pop_front();
                    if (rx_tdata !== beat.data) begin
                        check_errors++;
                        $display("[ERROR] t=%0t m_rx_axis_tdata expected %02h got %02h",
                                 $time, beat.data, rx_tdata);
                    end
                    if (rx_tlast !== beat.last) begin
                        check_errors++;
                        $display("[ERROR] t=%0t m_rx_axis_tlast expected %0b got %0b",
                                 $time, beat.last, rx_tlast);
                    end
                end
            end
            if (txctl) begin
                if (!ctl_q) begin
                    if (framed && low_cnt < MIN_GAP) begin
                        check_errors++;
                        $display("[ERROR] t=%0t rgmii_phy_txctl low cycles expected >= %0d got %0d",
                                 $time, MIN_GAP, low_cnt);
                    end
                    high_cnt = 0;
                end
                high_cnt++;
                if (exp_nibs.size() == 0) begin
                    check_errors++;
                    $display("Line went active at %0t with no frame queued", $time);
                end else begin
                    nib = exp_nibs.pop_front();
                    if (txd !== nib) begin
                        check_errors++;
                        $display("[ERROR] t=%0t rgmii_phy_txd expected %h got %h",
                                 $time, nib, txd);
                    end
                end
            end else if (ctl_q) begin
                framed  = 1'b1;
                low_cnt = 0;
                if (exp_lens.size() == 0) begin
                    check_errors++;
                    $display("Line frame ended at %0t with no length expected", $time);
                end else begin
                    len = exp_lens.pop_front();
                    if (high_cnt != len) begin
                        check_errors++;
                        $display("[ERROR] t=%0t rgmii_phy_txctl high cycles expected %0d got %0d",
                                 $time, len, high_cnt);
                    end
                end
            end
            if (!txctl) begin
                low_cnt++;
            end
            ctl_q = txctl;
        end
    end

endmodule

// ==== tb/ethernet_mac_top_tb.sv ====
`include "eth_settings.svh"

module ethernet_mac_top_tb
    import eth_stream_pkg::*;
    import rgmii_line_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam eth_byte_t SFD          = `ETH_SFD;
    localparam int        MAX_BYTES    = 14;
    localparam int        LOOP_FRAMES  = 20;
    localparam int        BP_FRAMES    = 10;
    localparam int        NUM_FRAMES   = LOOP_FRAMES + BP_FRAMES;
    localparam int        OVF_BYTES    = 24;
    localparam int        DIRECT_BYTES = 9;
    localparam int        PRE_NIBS     = 2 * `ETH_PREAMBLE_BYTES + 1;  // Delimiter low nibble too
    localparam int        LINE_EXTRA   = 2 * `ETH_PREAMBLE_BYTES + 2 + 2 * `ETH_IFG_BYTES;
    localparam int        OVF_KEEP     = `ETH_FIFO_DEPTH + 1;  // FIFO plus the stalled beat

    logic       clk_125;
    logic       rst_n;
    logic [3:0] rgmii_phy_rxd;
    logic       rgmii_phy_rxctl;
    logic [3:0] rgmii_phy_txd;
    logic       rgmii_phy_txctl;
    logic [7:0] s_tx_axis_tdata;
    logic       s_tx_axis_tvalid;
    logic       s_tx_axis_tlast;
    logic       s_tx_axis_trdy;
    logic [7:0] m_rx_axis_tdata;
    logic       m_rx_axis_tvalid;
    logic       m_rx_axis_tlast;
    logic       m_rx_axis_trdy;
    logic       rx_overflow;
    nibble_t    drv_rxd;
    logic       drv_rxctl;
    logic       loopback;
    int         seed;
    int         stall_mode;  // 0 ready, 1 random stalls, 2 held off
    int         wd_cycles = 0;
    int         frame_len[NUM_FRAMES];
    eth_byte_t  frame_bytes[32];

    assign rgmii_phy_rxd   = loopback ? rgmii_phy_txd : drv_rxd;
    assign rgmii_phy_rxctl = loopback ? rgmii_phy_txctl : drv_rxctl;

    eth_clk_gen i_clk_gen (
        .clk_125 (clk_125),
        .rst_n   (rst_n)
    );

    ethernet_mac_fifo i_ethernet_mac_fifo (
        .clk_125          (clk_125),
        .rst_n            (rst_n),
        .rgmii_phy_rxd    (rgmii_phy_rxd),
        .rgmii_phy_rxctl  (rgmii_phy_rxctl),
        .rgmii_phy_txd    (rgmii_phy_txd),
        .rgmii_phy_txctl  (rgmii_phy_txctl),
        .s_tx_axis_tdata  (s_tx_axis_tdata),
        .s_tx_axis_tvalid (s_tx_axis_tvalid),
        .s_tx_axis_tlast  (s_tx_axis_tlast),
        .s_tx_axis_trdy   (s_tx_axis_trdy),
        .m_rx_axis_tdata  (m_rx_axis_tdata),
        .m_rx_axis_tvalid (m_rx_axis_tvalid),
        .m_rx_axis_tlast  (m_rx_axis_tlast),
        .m_rx_axis_trdy   (m_rx_axis_trdy),
        .rx_overflow      (rx_overflow)
    );

    eth_frame_checker i_checker (
        .clk_125     (clk_125),
        .rst_n       (rst_n),
        .txd         (rgmii_phy_txd),
        .txctl       (rgmii_phy_txctl),
        .rx_tdata    (m_rx_axis_tdata),
        .rx_tvalid   (m_rx_axis_tvalid),
        .rx_tlast    (m_rx_axis_tlast),
        .rx_trdy     (m_rx_axis_trdy),
        .rx_overflow (rx_overflow)
    );

    // Expected line nibbles and received beats for the bytes in frame_bytes
    function automatic void expected_frame(input int n, input int keep, input logic on_line);
        if (on_line) begin
            for (int i = 0; i < 2 * `ETH_PREAMBLE_BYTES; i++) begin
                i_checker.expect_nibble(4'h5);
            end
            i_checker.expect_nibble(SFD[3:0]);
            i_checker.expect_nibble(SFD[7:4]);
            for (int i = 0; i < n; i++) begin
                i_checker.expect_nibble(frame_bytes[i][3:0]);  // Low nibble first
                i_checker.expect_nibble(frame_bytes[i][7:4]);
            end
            i_checker.expect_line_len(2 * `ETH_PREAMBLE_BYTES + 2 + 2 * n);
        end
        for (int i = 0; i < keep; i++) begin
            i_checker.expect_beat(frame_bytes[i], i == keep - 1);
        end
    endfunction

    task automatic fill_frame(input int n);
        for (int i = 0; i < n; i++) begin
            frame_bytes[i] = eth_byte_t'($random(seed));
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_byte(input eth_byte_t data, input logic last);
        logic taken;
        s_tx_axis_tdata  = data;
        s_tx_axis_tvalid = 1'b1;
        s_tx_axis_tlast  = last;
        taken            = 1'b0;
        while (!taken) begin
            taken = s_tx_axis_trdy;
            @(negedge clk_125);
        end
    endtask

    task automatic send_tx_frame(input int n);
        fill_frame(n);
        expected_frame(n, n, 1'b1);
        for (int i = 0; i < n; i++) begin
            send_byte(frame_bytes[i], i == n - 1);
        end
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast  = 1'b0;
    endtask

    task automatic drive_line_frame(input int n, input int pre);
        drv_rxctl = 1'b1;
        for (int i = 0; i < pre; i++) begin
            drv_rxd = 4'h5;
            @(negedge clk_125);
        end
        drv_rxd = SFD[7:4];
        @(negedge clk_125);
        for (int i = 0; i < n; i++) begin
            drv_rxd = frame_bytes[i][3:0];
            @(negedge clk_125);
            drv_rxd = frame_bytes[i][7:4];
            @(negedge clk_125);
        end
        drv_rxctl = 1'b0;
        drv_rxd   = '0;
        repeat (2 * `ETH_IFG_BYTES) @(negedge clk_125);
    endtask

    task automatic wait_drained();
        while (i_checker.outstanding() != 0) begin
            @(negedge clk_125);
        end
    endtask

    initial begin : rx_ready_drive
        m_rx_axis_trdy = 1'b1;
        forever begin
            @(negedge clk_125);
            case (stall_mode)
                0: m_rx_axis_trdy = 1'b1;
                1: m_rx_axis_trdy = ($random(seed) % 4) != 0;
                default: m_rx_axis_trdy = 1'b0;
            endcase
        end
    end

    initial begin : watchdog
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_125);
        $display("Timeout: the tests did not finish within %0d clock cycles", wd_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        int total;
        seed             = 47;
        loopback         = 1'b1;
        stall_mode       = 0;
        s_tx_axis_tdata  = '0;
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast  = 1'b0;
        drv_rxd          = '0;
        drv_rxctl        = 1'b0;
        total            = 2 * LINE_EXTRA + 2 * (OVF_BYTES + DIRECT_BYTES);
        for (int i = 0; i < NUM_FRAMES; i++) begin
            frame_len[i] = 1 + int'($unsigned($random(seed)) % MAX_BYTES);
            total += LINE_EXTRA + 2 * frame_len[i];
        end
        wd_cycles = 4 * total + 400;
        wait (rst_n === 1'b1);
        @(negedge clk_125);

        i_checker.start_test();
        for (int f = 0; f < LOOP_FRAMES; f++) begin
            send_tx_frame(frame_len[f]);
        end
        wait_drained();
        i_checker.finish_test("loopback", 0);

        i_checker.start_test();
        stall_mode = 1;
        for (int f = LOOP_FRAMES; f < NUM_FRAMES; f++) begin
            send_tx_frame(frame_len[f]);
        end
        wait_drained();
        stall_mode = 0;
        i_checker.finish_test("rx back-pressure", 0);

        // Rx FIFO held full, the rest of the frame is dropped
        i_checker.start_test();
        loopback   = 1'b0;
        stall_mode = 2;
        repeat (2) @(negedge clk_125);
        fill_frame(OVF_BYTES);
        expected_frame(OVF_BYTES, OVF_KEEP, 1'b0);
        drive_line_frame(OVF_BYTES, PRE_NIBS);
        stall_mode = 0;
        wait_drained();
        repeat (8) @(negedge clk_125);
        i_checker.finish_test("rx overflow", 1);

        i_checker.start_test();
        fill_frame(DIRECT_BYTES);
        expected_frame(DIRECT_BYTES, DIRECT_BYTES, 1'b0);
        drive_line_frame(DIRECT_BYTES, PRE_NIBS + 6);  // Longer preamble than usual
        wait_drained();
        i_checker.finish_test("direct receive", 0);

        i_checker.print_summary();
        if (i_checker.total_errors() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+logic
logic/eth_stream_pkg.sv
logic/rgmii_line_pkg.sv
logic/axis_if.sv
logic/beat_fifo.sv
logic/rgmii_tx_framer.sv
logic/rgmii_rx_deframer.sv
logic/ethernet_mac_fifo.sv
tb/eth_clk_gen.sv
tb/eth_frame_checker.sv
tb/ethernet_mac_top_tb.sv

// ==== Bender.yml ====
package:
  name: ethernet_mac_fifo

export_include_dirs:
  - logic

sources:
  - files:
      - logic/eth_stream_pkg.sv
      - logic/rgmii_line_pkg.sv
      - logic/axis_if.sv
      - logic/beat_fifo.sv
      - logic/rgmii_tx_framer.sv
      - logic/rgmii_rx_deframer.sv
      - logic/ethernet_mac_fifo.sv
  - target: test
    files:
      - tb/eth_clk_gen.sv
      - tb/eth_frame_checker.sv
      - tb/ethernet_mac_top_tb.sv
